// ==== hdl/audio_params.svh ====
`ifndef AUDIO_PARAMS_SVH
`define AUDIO_PARAMS_SVH

//////////////////////////////
// Sample and slot geometry
//////////////////////////////

// Signed PCM sample width
`define AUDIO_SAMPLE_W 24

// Bit clocks per channel slot, two slots per frame
`define AUDIO_SLOT_W 32

//////////////////////////////
// Timing and buffering
//////////////////////////////

// clk_soc cycles per bit clock period, must be even
`define AUDIO_BCLK_DIV 4

// Stereo frames queued ahead of the serializer, power of two
`define AUDIO_FIFO_DEPTH 4

// Reset stretch counter width, all ones is the held count
`define AUDIO_RESET_W 6

// Quarter-wave table entries, one quadrant of the wave
`define AUDIO_TABLE_DEPTH 64

`endif

// ==== hdl/audio_pkg.sv ====
`include "audio_params.svh"

package audio_pkg;

    //////////////////////////////
    // Sample word
    //////////////////////////////

    // One signed PCM word, two's complement
    typedef logic signed [`AUDIO_SAMPLE_W-1:0] sample_t;

    //////////////////////////////
    // Stereo frame
    //////////////////////////////

    // Same bits seen two ways
    // FIFO side writes the channels, serializer shifts the raw word
    typedef union packed {
        // Left in the upper half, so it leaves the shifter first
        struct packed {
            sample_t left;
            sample_t right;
        } lr;
        // Flat view for MSB-first shifting
        logic [2*`AUDIO_SAMPLE_W-1:0] raw;
    } audio_frame_u;

endpackage

// ==== hdl/reset_stretcher.sv ====
`timescale 1ns/1ps
`include "audio_params.svh"

module reset_stretcher (
    input  logic clk_soc,
    input  logic rst_n,
    input  logic restart,
    output logic reset
);

    // Down-counter, nonzero means reset still held
    logic [`AUDIO_RESET_W-1:0] stretch_cnt;

    //////////////////////////////
    // Stretch counter
    //////////////////////////////

    always_ff @(posedge clk_soc or negedge rst_n) begin
        if (!rst_n) begin
            // Async board reset loads the full count
            stretch_cnt <= '1;
        end else if (restart) begin
            // Button press reloads, sync to clk_soc
            stretch_cnt <= '1;
        end else if (stretch_cnt != '0) begin
            stretch_cnt <= stretch_cnt - 1'b1;
        end
    end

    // Held until the count runs out
    // 63 cycles after rst_n high and restart low
    assign reset = |stretch_cnt;

endmodule

// ==== hdl/sine_generator.sv ====
`timescale 1ns/1ps
`include "audio_params.svh"

module sine_generator (
    input  logic               clk_soc,
    input  logic               rst_n,
    input  logic               reset,
    input  logic [7:0]         step,
    input  logic               ready,
    output logic               valid,
    output audio_pkg::sample_t sample
);
    import audio_pkg::*;

    //////////////////////////////
    // Quarter-wave table
    //////////////////////////////

    // sin(2*pi*k/256) scaled to 2^23, k = 0..63
    localparam sample_t quarter_wave [`AUDIO_TABLE_DEPTH] = '{
        24'h000000, 24'h03242B, 24'h0647D9, 24'h096A90, 24'h0C8BD3, 24'h0FAB27,
        24'h12C810, 24'h15E214, 24'h18F8B8, 24'h1C0B82, 24'h1F19F9, 24'h2223A5,
        24'h25280C, 24'h2826B9, 24'h2B1F35, 24'h2E110A, 24'h30FBC5, 24'h33DEF3,
        24'h36BA20, 24'h398CDD, 24'h3C56BA, 24'h3F174A, 24'h41CE1E, 24'h447ACD,
        24'h471CED, 24'h49B415, 24'h4C3FE0, 24'h4EBFE9, 24'h5133CD, 24'h539B2B,
        24'h55F5A5, 24'h5842DD, 24'h5A827A, 24'h5CB421, 24'h5ED77D, 24'h60EC38,
        24'h62F202, 24'h64E889, 24'h66CF81, 24'h68A69F, 24'h6A6D99, 24'h6C2429,
        24'h6DCA0D, 24'h6F5F03, 24'h70E2CC, 24'h72552D, 24'h73B5EC, 24'h7504D3,
        24'h7641AF, 24'h776C4F, 24'h788484, 24'h798A24, 24'h7A7D05, 24'h7B5D04,
        24'h7C29FC, 24'h7CE3CF, 24'h7D8A5F, 24'h7E1D94, 24'h7E9D56, 24'h7F0992,
        24'h7F6237, 24'h7FA737, 24'h7FD888, 24'h7FF622
    };

    // Crest at k = 64 lies past the table end
    localparam sample_t full_scale = {1'b0, {(`AUDIO_SAMPLE_W-1){1'b1}}};

    // Phase state and latched step
    logic [7:0] phase;
    logic [7:0] step_q;

    // Quadrant folding
    logic [1:0] quadrant;
    logic [5:0] offset;
    logic [5:0] index;
    sample_t    magnitude;

    //////////////////////////////
    // Phase accumulator
    //////////////////////////////

    always_ff @(posedge clk_soc or negedge rst_n) begin
        if (!rst_n) begin
            phase  <= '0;
            step_q <= '0;
            valid  <= 1'b0;
        end else if (reset) begin
            // Switches sampled for as long as reset is held
            phase  <= '0;
            step_q <= step;
            valid  <= 1'b0;
        end else begin
            // Always something to offer once out of reset
            valid <= 1'b1;
            // Advance only on transfer, wraps mod 256
            if (valid && ready) begin
                phase <= phase + step_q;
            end
        end
    end

    //////////////////////////////
    // Fold phase onto the table
    //////////////////////////////

    assign quadrant = phase[7:6];
    assign offset   = phase[5:0];

    // Odd quadrants run backwards through the table
    assign index = quadrant[0] ? 6'd0 - offset : offset;

    always_comb begin
        // Falling quadrant starts at the crest
        if (quadrant[0] && offset == 6'd0) begin
            magnitude = full_scale;
        end else begin
            magnitude = quarter_wave[index];
        end
    end

    // Second half of the wave is negative
    // Held steady by the phase register under back-pressure
    assign sample = quadrant[1] ? -magnitude : magnitude;

endmodule

// ==== hdl/i2s_serializer.sv ====
`timescale 1ns/1ps
`include "audio_params.svh"

module i2s_serializer (
    input  logic                   clk_soc,
    input  logic                   rst_n,
    input  logic                   reset,
    input  audio_pkg::audio_frame_u frame,
    input  logic                   frame_valid,
    output logic                   frame_take,
    output logic                   bclk,
    output logic                   lrclk,
    output logic                   sdata
);
    import audio_pkg::*;

    //////////////////////////////
    // Geometry
    //////////////////////////////

    localparam int div_w   = $clog2(`AUDIO_BCLK_DIV);
    localparam int frame_w = $clog2(2 * `AUDIO_SLOT_W);
    localparam int slot_w  = $clog2(`AUDIO_SLOT_W);
    localparam int raw_w   = 2 * `AUDIO_SAMPLE_W;

    // Divider phases for the two bclk edges
    localparam logic [div_w-1:0] rise_at = div_w'(`AUDIO_BCLK_DIV / 2 - 1);
    localparam logic [div_w-1:0] fall_at = div_w'(`AUDIO_BCLK_DIV - 1);
    // Last data position inside a slot, after the one-bit delay
    localparam logic [slot_w-1:0] data_last = slot_w'(`AUDIO_SAMPLE_W);

    logic               running;
    logic [div_w-1:0]   div_cnt;
    logic [frame_w-1:0] bit_cnt;
    logic [frame_w-1:0] bit_next;
    logic [slot_w-1:0]  slot_pos;
    logic               fall_evt;
    logic               wrap;
    logic               data_slot;

    // Shift word, raw view of the frame
    audio_frame_u shreg;

    //////////////////////////////
    // Bit position decode
    //////////////////////////////

    assign fall_evt = running && (div_cnt == fall_at);
    assign bit_next = bit_cnt + 1'b1;
    assign slot_pos = bit_next[slot_w-1:0];
    // Position 0 is the I2S delay bit, sample follows, then zero fill
    assign data_slot = (slot_pos != '0) && (slot_pos <= data_last);
    // End of the right slot
    assign wrap = fall_evt && (bit_cnt == '1);

    // Pop on the first load and at each frame boundary
    assign frame_take = frame_valid && (!running || wrap);

    //////////////////////////////
    // Bit clock and framing
    //////////////////////////////

    always_ff @(posedge clk_soc or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
            bclk    <= 1'b0;
            lrclk   <= 1'b0;
            sdata   <= 1'b0;
        end else if (reset) begin
            running <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
            bclk    <= 1'b0;
            lrclk   <= 1'b0;
            sdata   <= 1'b0;
        end else if (!running) begin
            // Lines stay low until the first frame shows up
            if (frame_valid) begin
                running <= 1'b1;
                div_cnt <= '0;
                bit_cnt <= '0;
            end
        end else begin
            if (div_cnt == fall_at) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            if (div_cnt == rise_at) begin
                bclk <= 1'b1;
            end
            // Everything moves on the falling edge
            if (fall_evt) begin
                bclk    <= 1'b0;
                bit_cnt <= bit_next;
                // Low for left, high for right
                lrclk   <= bit_next[frame_w-1];
                sdata   <= data_slot ? shreg.raw[raw_w-1] : 1'b0;
            end
        end
    end

    //////////////////////////////
    // Shift register
    //////////////////////////////

    always_ff @(posedge clk_soc) begin
        if (frame_take) begin
            shreg <= frame;
        end else if (wrap) begin
            // Underflow sends silence
            shreg <= '0;
        end else if (fall_evt && data_slot) begin
            // MSB first, left half leaves before right
            shreg.raw <= {shreg.raw[raw_w-2:0], 1'b0};
        end
    end

endmodule

// ==== hdl/i2s_master.sv ====
`timescale 1ns/1ps
`include "audio_params.svh"

module i2s_master (
    input  logic               clk_soc,
    input  logic               rst_n,
    input  logic               reset,
    input  audio_pkg::sample_t frame_in_l,
    input  audio_pkg::sample_t frame_in_r,
    input  logic               write_frame,
    output logic               full,
    output logic               bclk,
    output logic               lrclk,
    output logic               sdata
);
    import audio_pkg::*;

    localparam int ptr_w = $clog2(`AUDIO_FIFO_DEPTH);
    localparam logic [ptr_w:0] depth_c = (ptr_w + 1)'(`AUDIO_FIFO_DEPTH);

    // Frame storage, no reset on the payload
    audio_frame_u mem [`AUDIO_FIFO_DEPTH];
    audio_frame_u wr_frame;
    audio_frame_u frame;

    // Circular pointers, natural wrap
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;

    logic push;
    logic pop;
    logic frame_valid;
    logic frame_take;

    //////////////////////////////
    // Write side
    //////////////////////////////

    // Pack both channels into one frame word
    always_comb begin
        wr_frame.lr.left  = frame_in_l;
        wr_frame.lr.right = frame_in_r;
    end

    assign push = write_frame && !full;
    assign pop  = frame_take;

    always_ff @(posedge clk_soc) begin
        if (push) begin
            mem[wr_ptr] <= wr_frame;
        end
    end

    //////////////////////////////
    // Pointers and occupancy
    //////////////////////////////

    always_ff @(posedge clk_soc or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign full        = (count == depth_c);
    // Up one cycle after the first write lands
    assign frame_valid = (count != '0);
    // Head of queue straight to the shifter
    assign frame       = mem[rd_ptr];

    //////////////////////////////
    // Serializer
    //////////////////////////////

    i2s_serializer serializer (
        .clk_soc     (clk_soc),
        .rst_n       (rst_n),
        .reset       (reset),
        .frame       (frame),
        .frame_valid (frame_valid),
        .frame_take  (frame_take),
        .bclk        (bclk),
        .lrclk       (lrclk),
        .sdata       (sdata)
    );

endmodule

// ==== hdl/audio_standalone_top.sv ====
`timescale 1ns/1ps

module audio_standalone_top (
    input  logic       clk_soc,
    input  logic       rst_n,
    input  logic [7:0] dip,
    input  logic       btn_c,
    input  logic       btn_d,
    input  logic       btn_l,
    input  logic       btn_r,
    input  logic       btn_u,
    output logic [7:0] led,
    output logic       bclk,
    output logic       lrclk,
    output logic       sdata
);
    import audio_pkg::*;

    // Stretched internal reset, active high
    logic    reset;
    // Generator to I2S handshake
    sample_t sample;
    logic    sample_valid;
    logic    fifo_full;

    //////////////////////////////
    // Reset
    //////////////////////////////

    // Centre button restarts the wave from phase zero
    reset_stretcher stretcher (
        .clk_soc (clk_soc),
        .rst_n   (rst_n),
        .restart (btn_c),
        .reset   (reset)
    );

    //////////////////////////////
    // Audio path
    //////////////////////////////

    // Step taken from the dip switches at reset release
    sine_generator generator (
        .clk_soc (clk_soc),
        .rst_n   (rst_n),
        .reset   (reset),
        .step    (dip),
        .ready   (~fifo_full),
        .valid   (sample_valid),
        .sample  (sample)
    );

    // Mono source, same sample on both channels
    i2s_master i2s (
        .clk_soc     (clk_soc),
        .rst_n       (rst_n),
        .reset       (reset),
        .frame_in_l  (sample),
        .frame_in_r  (sample),
        .write_frame (sample_valid),
        .full        (fifo_full),
        .bclk        (bclk),
        .lrclk       (lrclk),
        .sdata       (sdata)
    );

    // Debug LEDs, upper three always pass the switches
    assign led = dip & {3'b111, btn_c, btn_d, btn_l, btn_r, btn_u};

endmodule

// ==== dv/tb_audio_top.sv ====
`timescale 1ns/1ps
`include "audio_params.svh"

module tb_audio_top;
    import audio_pkg::*;

    localparam int stim_words    = 256;
    localparam int reset_timeout = 200;
    localparam int bclk_timeout  = 100;
    localparam int frame_bits    = 2 * `AUDIO_SLOT_W;

    logic       clk_soc;
    logic       rst_n;
    logic [7:0] dip;
    logic       btn_c;
    logic       btn_d;
    logic       btn_l;
    logic       btn_r;
    logic       btn_u;
    logic [7:0] led;
    logic       bclk;
    logic       lrclk;
    logic       sdata;

    // Step, count, then expected samples, case after case
    logic [`AUDIO_SAMPLE_W-1:0] stim_mem [stim_words];
    // Last bclk level seen, for edge detection
    logic bclk_prev;

    audio_standalone_top UUT (
        .clk_soc (clk_soc),
        .rst_n   (rst_n),
        .dip     (dip),
        .btn_c   (btn_c),
        .btn_d   (btn_d),
        .btn_l   (btn_l),
        .btn_r   (btn_r),
        .btn_u   (btn_u),
        .led     (led),
        .bclk    (bclk),
        .lrclk   (lrclk),
        .sdata   (sdata)
    );

    // 10 ns clk_soc
    always #5 clk_soc = ~clk_soc;

    //////////////////////////////
    // Compare and report
    //////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s: got 0x%06h expected 0x%06h", name, got, exp));
        end
    endtask

    task automatic check_led(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s: got 0x%02h expected 0x%02h", name, got, exp));
        end
    endtask

    task automatic check_line(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    //////////////////////////////
    // Bounded waits
    //////////////////////////////

    // Internal reset high, then low, with the I2S lines quiet while held
    task automatic wait_reset_release();
        int cycles;
        int held;
        cycles = 0;
        held   = 0;
        @(negedge clk_soc);
        while (UUT.reset !== 1'b1) begin
            cycles++;
            if (cycles > reset_timeout) begin
                abort_run("internal reset never asserted");
            end
            @(negedge clk_soc);
        end
        while (UUT.reset === 1'b1) begin
            held++;
            // First held cycle may still show the old bit clock
            if (held > 1) begin
                check_line("bclk in reset", bclk, 1'b0);
                check_line("lrclk in reset", lrclk, 1'b0);
                check_line("sdata in reset", sdata, 1'b0);
            end
            if (held > reset_timeout) begin
                abort_run("internal reset not released in time");
            end
            @(negedge clk_soc);
        end
        bclk_prev = 1'b0;
    endtask

    // Sampled mid-cycle, data is stable around bclk rise
    task automatic wait_bclk_rise(input bit quiet);
        int cycles;
        cycles = 0;
        @(negedge clk_soc);
        while (!(bclk === 1'b1 && bclk_prev === 1'b0)) begin
            // Nothing on the lines before the first frame
            if (quiet) begin
                check_line("lrclk before first frame", lrclk, 1'b0);
                check_line("sdata before first frame", sdata, 1'b0);
            end
            bclk_prev = bclk;
            cycles++;
            if (cycles > bclk_timeout) begin
                abort_run("no bit clock rising edge within the timeout");
            end
            @(negedge clk_soc);
        end
        bclk_prev = bclk;
    endtask

    //////////////////////////////
    // I2S capture
    //////////////////////////////

    // One 64-bit frame, delay bit then MSB first, zero fill
    task automatic capture_frame(input sample_t exp, input bit first, input int idx,
                                 output sample_t left);
        sample_t right;
        int      pos;
        int      slot_pos;
        left  = '0;
        right = '0;
        for (pos = 0; pos < frame_bits; pos++) begin
            wait_bclk_rise(first && pos == 0);
            // Low for left, high for right
            check_line($sformatf("lrclk frame %0d bit %0d", idx, pos), lrclk,
                       pos >= `AUDIO_SLOT_W);
            slot_pos = pos % `AUDIO_SLOT_W;
            if (slot_pos >= 1 && slot_pos <= `AUDIO_SAMPLE_W) begin
                // Sample bits, rebuilt MSB first
                if (pos < `AUDIO_SLOT_W) begin
                    left = {left[`AUDIO_SAMPLE_W-2:0], sdata};
                end else begin
                    right = {right[`AUDIO_SAMPLE_W-2:0], sdata};
                end
            end else begin
                // Delay bit and padding
                check_line($sformatf("sdata frame %0d pad bit %0d", idx, pos), sdata, 1'b0);
            end
        end
        check_sample($sformatf("left frame %0d", idx), left, exp);
        // Mono source on both channels
        check_sample($sformatf("right frame %0d", idx), right, exp);
    endtask

    //////////////////////////////
    // Test cases
    //////////////////////////////

    task automatic run_case(input int base, input bit use_button);
        logic [7:0] step;
        int         count;
        int         f;
        sample_t    left;
        step  = stim_mem[base][7:0];
        count = int'(stim_mem[base + 1]);
        if (use_button) begin
            // New step, then restart from the centre button
            @(posedge clk_soc);
            dip <= step;
            @(posedge clk_soc);
            btn_c <= 1'b1;
            repeat (2) @(posedge clk_soc);
            btn_c <= 1'b0;
        end
        wait_reset_release();
        for (f = 0; f < count; f++) begin
            // Switches moved without a reset, step must hold
            if (f > 0 && f == count / 2) begin
                @(posedge clk_soc);
                dip <= step ^ (8'($urandom) | 8'h01);
            end
            if ($isunknown(stim_mem[base + 2 + f])) begin
                abort_run("stimulus file ends inside a case");
            end
            capture_frame(stim_mem[base + 2 + f], f == 0, f, left);
            if (f == 0) begin
                check_sample("left at phase zero", left, '0);
            end
        end
    endtask

    task automatic check_leds_random();
        logic [7:0] dip_v;
        logic [4:0] btn_v;
        int         i;
        for (i = 0; i < 16; i++) begin
            dip_v = 8'($urandom);
            btn_v = 5'($urandom);
            @(posedge clk_soc);
            dip   <= dip_v;
            btn_c <= btn_v[4];
            btn_d <= btn_v[3];
            btn_l <= btn_v[2];
            btn_r <= btn_v[1];
            btn_u <= btn_v[0];
            @(negedge clk_soc);
            // Top three switches always shown, rest gated by c, d, l, r, u
            check_led("led", led, dip_v & {3'b111, btn_v});
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int base;
        int case_idx;
        void'($urandom(26531));
        clk_soc   = 1'b0;
        rst_n     = 1'b0;
        dip       = 8'h00;
        btn_c     = 1'b0;
        btn_d     = 1'b0;
        btn_l     = 1'b0;
        btn_r     = 1'b0;
        btn_u     = 1'b0;
        bclk_prev = 1'b0;
        $readmemh("dv/audio_stimulus.txt", stim_mem);
        if ($isunknown(stim_mem[0]) || $isunknown(stim_mem[1])) begin
            abort_run("stimulus file missing or empty");
        end
        // First case rides on the board reset
        dip = stim_mem[0][7:0];
        repeat (3) @(posedge clk_soc);
        rst_n <= 1'b1;
        base     = 0;
        case_idx = 0;
        while (stim_mem[base + 1] !== '0) begin
            if (base + 1 >= stim_words || $isunknown(stim_mem[base + 1])) begin
                abort_run("stimulus file has no end marker");
            end
            run_case(base, case_idx > 0);
            base += 2 + int'(stim_mem[base + 1]);
            case_idx++;
        end
        check_leds_random();
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+hdl
hdl/audio_pkg.sv
hdl/reset_stretcher.sv
hdl/sine_generator.sv
hdl/i2s_serializer.sv
hdl/i2s_master.sv
hdl/audio_standalone_top.sv
dv/tb_audio_top.sv

// ==== Bender.yml ====
package:
  name: audio_standalone

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/audio_pkg.sv
      - hdl/reset_stretcher.sv
      - hdl/sine_generator.sv
      - hdl/i2s_serializer.sv
      - hdl/i2s_master.sv
      - hdl/audio_standalone_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/tb_audio_top.sv

// ==== dv/audio_stimulus.txt ====
// Columns per case, all hex: dip step, frame count, then one expected left sample per frame
// A frame count of zero ends the list

// Quarter-cycle steps, crest and trough
40 05
000000 7FFFFF 000000 800001
000000

// Eighth-cycle steps, one full period plus wrap
20 09
000000 5A827A 7FFFFF 5A827A
000000 A57D86 800001 A57D86
000000

// Smallest step, start of the table
01 04
000000 03242B 0647D9 096A90

// First half period in sixteenths
10 06
000000 30FBC5 5A827A 7641AF
7FFFFF 7641AF

// Odd step, mirrored and negated quadrants
50 06
000000 7641AF A57D86 CF043B
7FFFFF CF043B

// Step of three quarters, runs backwards round the circle
C0 05
000000 800001 000000 7FFFFF
000000

// End marker
00 00
